// File: rtl/router_defines.svh
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// node id width for 16 nodes
`define NODE_ID_W 4

// one routing entry per node
`define NUM_NODES 16

// neighbor slots in the silence monitor
`define MAX_NEIGHBORS 8

// silent cycles before a neighbor is dropped
`define EXPIRE_CYCLES 200

// flit payload width
`define PAYLOAD_W 32

`endif

// File: rtl/router_pkg.sv
`default_nettype none
`include "router_defines.svh"

package router_pkg;

    typedef logic [`NODE_ID_W-1:0] node_id_t;

    // kind field of a flit
    typedef enum logic [1:0] {
        FLIT_DATA   = 2'd0,
        FLIT_ASSIGN = 2'd1,
        FLIT_RSVD_2 = 2'd2,
        FLIT_RSVD_3 = 2'd3
    } flit_kind_t;

    typedef struct packed {
        flit_kind_t            kind;
        node_id_t              src;
        node_id_t              dst;
        logic [`PAYLOAD_W-1:0] payload;
    } flit_t;

    // flit plus the neighbor it came in from
    typedef struct packed {
        flit_t    flit;
        node_id_t from_id;
    } rx_flit_t;

    typedef enum logic [1:0] {
        OP_DATA   = 2'd0,
        OP_ASSIGN = 2'd1,
        OP_DROP   = 2'd2
    } route_op_t;

    typedef struct packed {
        route_op_t op;
        flit_t     flit;
        node_id_t  from_id;
    } decoded_t;

    typedef enum logic [1:0] {
        DIR_CPU     = 2'd0,
        DIR_FORWARD = 2'd1,
        DIR_NONE    = 2'd2
    } route_dir_t;

    typedef struct packed {
        route_dir_t dir;
        node_id_t   next_hop;
        flit_t      flit;
    } routed_t;

    typedef struct packed {
        flit_t    flit;
        node_id_t next_hop;
    } tx_flit_t;

    typedef enum logic {
        UNASSIGNED = 1'b0,
        ASSIGNED   = 1'b1
    } node_state_t;

endpackage

`default_nettype wire

// File: rtl/flit_decode.sv
`timescale 1ns/1ps
`default_nettype none

module flit_decode
    import router_pkg::*;
(
    input  logic     nocclk,
    input  logic     rst_n,
    input  rx_flit_t in_flit,
    input  logic     in_valid,
    input  logic     advance,
    output decoded_t dec,
    output logic     dec_valid,
    output logic     heard_valid,
    output node_id_t heard_id
);

    route_op_t op;
    logic      accept;

    // in_ready is advance, so this is the handshake
    assign accept = in_valid && advance;

    // malformed flits become drops
    always_comb begin
        case (in_flit.flit.kind)
            FLIT_DATA:                op = OP_DATA;
            FLIT_ASSIGN:              op = OP_ASSIGN;
            FLIT_RSVD_2, FLIT_RSVD_3: op = OP_DROP;
            default:                  op = OP_DROP;
        endcase
        if (in_flit.flit.src == in_flit.flit.dst) begin
            op = OP_DROP;
        end
    end

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            dec_valid   <= 1'b0;
            heard_valid <= 1'b0;
        end else begin
            if (advance) begin
                dec_valid <= in_valid;
            end
            heard_valid <= accept;
        end
    end

    always_ff @(posedge nocclk) begin
        if (accept) begin
            dec.op      <= op;
            dec.flit    <= in_flit.flit;
            dec.from_id <= in_flit.from_id;
            heard_id    <= in_flit.from_id;
        end
    end

endmodule

`default_nettype wire

// File: rtl/route_execute.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defines.svh"

module route_execute
    import router_pkg::*;
(
    input  logic     nocclk,
    input  logic     rst_n,
    input  decoded_t dec,
    input  logic     dec_valid,
    input  logic     advance,
    input  logic     expire_valid,
    input  node_id_t expire_id,
    output routed_t  routed,
    output logic     routed_valid,
    output node_id_t node_id,
    output logic     node_assigned
);

    node_state_t           state;
    node_id_t              self_id;
    logic                  parent_valid;
    node_id_t              parent_id;
    logic [`NUM_NODES-1:0] tbl_valid;
    node_id_t              tbl_hop [`NUM_NODES];

    logic       step;
    logic       do_assign;
    logic       do_learn;
    route_dir_t dir;
    node_id_t   hop;

    assign step      = advance && dec_valid;
    assign do_assign = step && (dec.op == OP_ASSIGN) && (state == UNASSIGNED);
    assign do_learn  = step && (dec.op == OP_DATA) && (state == ASSIGNED);

    ////////////////////////////////////////////////////////////////////////////
    // lookup sees the table before this edge's learning
    always_comb begin
        dir = DIR_NONE;
        hop = self_id;
        if (dec.op == OP_DATA && state == ASSIGNED) begin
            if (dec.flit.dst == self_id) begin
                dir = DIR_CPU;
            end else if (tbl_valid[dec.flit.dst]) begin
                dir = DIR_FORWARD;
                hop = tbl_hop[dec.flit.dst];
            end else if (parent_valid) begin
                // default route
                dir = DIR_FORWARD;
                hop = parent_id;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // node state and parent
    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            state        <= UNASSIGNED;
            self_id      <= '0;
            parent_valid <= 1'b0;
        end else if (expire_valid) begin
            if (parent_id == expire_id) begin
                parent_valid <= 1'b0;
            end
        end else if (do_assign) begin
            state        <= ASSIGNED;
            self_id      <= dec.flit.dst;
            parent_valid <= 1'b1;
        end
    end

    always_ff @(posedge nocclk) begin
        if (do_assign) begin
            parent_id <= dec.from_id;
        end
    end

    // routing table learned from src
    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            tbl_valid <= '0;
        end else if (expire_valid) begin
            for (int i = 0; i < `NUM_NODES; i++) begin
                if (tbl_hop[i] == expire_id) begin
                    tbl_valid[i] <= 1'b0;
                end
            end
        end else if (do_learn) begin
            tbl_valid[dec.flit.src] <= 1'b1;
        end
    end

    always_ff @(posedge nocclk) begin
        if (do_learn) begin
            tbl_hop[dec.flit.src] <= dec.from_id;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage register
    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            routed_valid <= 1'b0;
        end else if (advance) begin
            routed_valid <= dec_valid;
        end
    end

    always_ff @(posedge nocclk) begin
        if (advance) begin
            routed.dir      <= dir;
            routed.next_hop <= hop;
            routed.flit     <= dec.flit;
        end
    end

    assign node_id       = self_id;
    assign node_assigned = (state == ASSIGNED);

endmodule

`default_nettype wire

// File: rtl/neighbor_monitor.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defines.svh"

module neighbor_monitor
    import router_pkg::*;
(
    input  logic     nocclk,
    input  logic     rst_n,
    input  logic     heard_valid,
    input  node_id_t heard_id,
    output logic     expire_valid,
    output node_id_t expire_id
);

    localparam int CNT_W  = $clog2(`EXPIRE_CYCLES + 1);
    localparam int SLOT_W = $clog2(`MAX_NEIGHBORS);

    node_id_t                  slot_id  [`MAX_NEIGHBORS];
    logic [CNT_W-1:0]          slot_cnt [`MAX_NEIGHBORS];
    logic [`MAX_NEIGHBORS-1:0] slot_busy;

    logic              exp_hit;
    logic [SLOT_W-1:0] exp_slot;
    logic              match_hit;
    logic [SLOT_W-1:0] match_slot;
    logic              free_hit;
    logic [SLOT_W-1:0] free_slot;
    logic              claim;
    logic [SLOT_W-1:0] claim_slot;

    // descending priority search so the lowest slot wins
    always_comb begin
        exp_hit    = 1'b0;
        exp_slot   = '0;
        match_hit  = 1'b0;
        match_slot = '0;
        free_hit   = 1'b0;
        free_slot  = '0;
        for (int i = `MAX_NEIGHBORS - 1; i >= 0; i--) begin
            if (slot_busy[i] && slot_cnt[i] == CNT_W'(`EXPIRE_CYCLES)) begin
                exp_hit  = 1'b1;
                exp_slot = SLOT_W'(i);
            end
            if (slot_busy[i] && slot_id[i] == heard_id) begin
                match_hit  = 1'b1;
                match_slot = SLOT_W'(i);
            end
            if (!slot_busy[i]) begin
                free_hit  = 1'b1;
                free_slot = SLOT_W'(i);
            end
        end
    end

    // known id restarts its slot, new id takes a free one
    assign claim      = heard_valid && (match_hit || free_hit);
    assign claim_slot = match_hit ? match_slot : free_slot;

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            slot_busy <= '0;
        end else begin
            if (exp_hit) begin
                slot_busy[exp_slot] <= 1'b0;
            end
            if (claim) begin
                slot_busy[claim_slot] <= 1'b1;
            end
        end
    end

    // counters saturate until their slot is served
    always_ff @(posedge nocclk) begin
        for (int i = 0; i < `MAX_NEIGHBORS; i++) begin
            if (slot_busy[i] && slot_cnt[i] != CNT_W'(`EXPIRE_CYCLES)) begin
                slot_cnt[i] <= slot_cnt[i] + 1'b1;
            end
        end
        if (claim) begin
            slot_cnt[claim_slot] <= '0;
            slot_id[claim_slot]  <= heard_id;
        end
    end

    assign expire_valid = exp_hit;
    assign expire_id    = slot_id[exp_slot];

endmodule

`default_nettype wire

// File: rtl/route_result.sv
`timescale 1ns/1ps
`default_nettype none

module route_result
    import router_pkg::*;
(
    input  logic     nocclk,
    input  logic     rst_n,
    input  routed_t  routed,
    input  logic     routed_valid,
    input  logic     advance,
    input  logic     cpu_ready,
    input  logic     fwd_ready,
    output flit_t    cpu_flit,
    output logic     cpu_valid,
    output tx_flit_t fwd_flit,
    output logic     fwd_valid,
    output logic     blocked
);

    routed_t held;
    logic    held_valid;

    // DIR_NONE records turn into bubbles here
    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else if (advance) begin
            held_valid <= routed_valid && (routed.dir != DIR_NONE);
        end else if (!blocked) begin
            // stalled by expiry, but the held flit left this edge
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge nocclk) begin
        if (advance) begin
            held <= routed;
        end
    end

    assign cpu_valid = held_valid && (held.dir == DIR_CPU);
    assign fwd_valid = held_valid && (held.dir == DIR_FORWARD);

    assign cpu_flit          = held.flit;
    assign fwd_flit.flit     = held.flit;
    assign fwd_flit.next_hop = held.next_hop;

    assign blocked = (cpu_valid && !cpu_ready) || (fwd_valid && !fwd_ready);

endmodule

`default_nettype wire

// File: rtl/noc_router.sv
`timescale 1ns/1ps
`default_nettype none

module noc_router
    import router_pkg::*;
(
    input  logic     nocclk,
    input  logic     rst_n,
    input  rx_flit_t in_flit,
    input  logic     in_valid,
    output logic     in_ready,
    output flit_t    cpu_flit,
    output logic     cpu_valid,
    input  logic     cpu_ready,
    output tx_flit_t fwd_flit,
    output logic     fwd_valid,
    input  logic     fwd_ready,
    output node_id_t node_id,
    output logic     node_assigned
);

    decoded_t dec;
    logic     dec_valid;
    routed_t  routed;
    logic     routed_valid;
    logic     heard_valid;
    node_id_t heard_id;
    logic     expire_valid;
    node_id_t expire_id;
    logic     blocked;
    logic     advance;

    // whole pipeline moves together, expiry takes one cycle of its own
    assign advance  = !(blocked || expire_valid);
    assign in_ready = advance;

    ////////////////////////////////////////////////////////////////////////////
    // decode, execute, result
    flit_decode flit_decode_i (
        .nocclk      (nocclk),
        .rst_n       (rst_n),
        .in_flit     (in_flit),
        .in_valid    (in_valid),
        .advance     (advance),
        .dec         (dec),
        .dec_valid   (dec_valid),
        .heard_valid (heard_valid),
        .heard_id    (heard_id)
    );

    route_execute route_execute_i (
        .nocclk        (nocclk),
        .rst_n         (rst_n),
        .dec           (dec),
        .dec_valid     (dec_valid),
        .advance       (advance),
        .expire_valid  (expire_valid),
        .expire_id     (expire_id),
        .routed        (routed),
        .routed_valid  (routed_valid),
        .node_id       (node_id),
        .node_assigned (node_assigned)
    );

    route_result route_result_i (
        .nocclk       (nocclk),
        .rst_n        (rst_n),
        .routed       (routed),
        .routed_valid (routed_valid),
        .advance      (advance),
        .cpu_ready    (cpu_ready),
        .fwd_ready    (fwd_ready),
        .cpu_flit     (cpu_flit),
        .cpu_valid    (cpu_valid),
        .fwd_flit     (fwd_flit),
        .fwd_valid    (fwd_valid),
        .blocked      (blocked)
    );

    ////////////////////////////////////////////////////////////////////////////
    // neighbor silence tracking
    neighbor_monitor neighbor_monitor_i (
        .nocclk       (nocclk),
        .rst_n        (rst_n),
        .heard_valid  (heard_valid),
        .heard_id     (heard_id),
        .expire_valid (expire_valid),
        .expire_id    (expire_id)
    );

endmodule

`default_nettype wire

// File: tests/noc_router_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "router_defines.svh"

module noc_router_tb
    import router_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int REFRESH_GAP = 50;
    localparam int REFRESHES   = (`EXPIRE_CYCLES + 40) / REFRESH_GAP + 1;
    // rough test lengths in cycles for the watchdog
    localparam int SHORT_TEST  = 60;
    localparam int EXPIRY_TEST = REFRESHES * (REFRESH_GAP + 20) + `EXPIRE_CYCLES + 140;
    localparam int RUN_LIMIT   = 5 * SHORT_TEST + EXPIRY_TEST + 200;

    localparam node_id_t SELF   = 4'd6;
    localparam node_id_t PARENT = 4'd3;

    logic     nocclk;
    logic     rst_n;
    rx_flit_t in_flit;
    logic     in_valid;
    logic     in_ready;
    flit_t    cpu_flit;
    logic     cpu_valid;
    logic     cpu_ready;
    tx_flit_t fwd_flit;
    logic     fwd_valid;
    logic     fwd_ready;
    node_id_t node_id;
    logic     node_assigned;

    int       seed;
    int       cycle;
    int       errors;
    string    test_name;
    flit_t    cpu_exp [$];
    tx_flit_t fwd_exp [$];

    // reference model of node state, parent and table
    logic     m_assigned;
    node_id_t m_self;
    logic     m_parent_valid;
    node_id_t m_parent;
    logic     m_tbl_valid [`NUM_NODES];
    node_id_t m_tbl_hop   [`NUM_NODES];
    logic     m_alive     [`NUM_NODES];
    int       m_heard_at  [`NUM_NODES];

    noc_router noc_router_i (.*);

    always #(CLK_PERIOD / 2) nocclk = ~nocclk;

    always @(posedge nocclk) begin
        if (!rst_n) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // error reporting
    task automatic fail_run();
        errors++;
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic mismatch(input string what, input logic [63:0] expected,
                            input logic [63:0] actual);
        $display("FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
        fail_run();
    endtask

    task automatic report_error(input string msg);
        $display("error in %s: %s", test_name, msg);
        fail_run();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    function automatic void age_model();
        for (int h = 0; h < `NUM_NODES; h++) begin
            if (m_alive[h] && cycle - m_heard_at[h] > `EXPIRE_CYCLES + 1) begin
                m_alive[h] = 1'b0;
                for (int e = 0; e < `NUM_NODES; e++) begin
                    if (m_tbl_hop[e] == node_id_t'(h)) begin
                        m_tbl_valid[e] = 1'b0;
                    end
                end
                if (m_parent == node_id_t'(h)) begin
                    m_parent_valid = 1'b0;
                end
            end
        end
    endfunction

    task automatic model_accept(input rx_flit_t f);
        flit_t    fl;
        tx_flit_t tx;
        logic     good;
        fl   = f.flit;
        good = (fl.src != fl.dst);
        age_model();
        m_alive[f.from_id]    = 1'b1;
        m_heard_at[f.from_id] = cycle;
        if (good && fl.kind == FLIT_ASSIGN && !m_assigned) begin
            m_assigned     = 1'b1;
            m_self         = fl.dst;
            m_parent_valid = 1'b1;
            m_parent       = f.from_id;
        end else if (good && fl.kind == FLIT_DATA && m_assigned) begin
            tx.flit = fl;
            // lookup sees the table before this flit's own learning
            if (fl.dst == m_self) begin
                cpu_exp.push_back(fl);
            end else if (m_tbl_valid[fl.dst]) begin
                tx.next_hop = m_tbl_hop[fl.dst];
                fwd_exp.push_back(tx);
            end else if (m_parent_valid) begin
                tx.next_hop = m_parent;
                fwd_exp.push_back(tx);
            end
            m_tbl_valid[fl.src] = 1'b1;
            m_tbl_hop[fl.src]   = f.from_id;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge nocclk);
            #1;
        end
    endtask

    task automatic send_flit(input flit_kind_t kind, input node_id_t src, input node_id_t dst,
                             input node_id_t from_id);
        rx_flit_t f;
        logic     taken;
        int       waited;
        f.flit.kind    = kind;
        f.flit.src     = src;
        f.flit.dst     = dst;
        f.flit.payload = $random(seed);
        f.from_id      = from_id;
        in_flit  = f;
        in_valid = 1'b1;
        taken    = 1'b0;
        waited   = 0;
        while (!taken && waited < 50) begin
            @(negedge nocclk);
            taken = in_ready;
            @(posedge nocclk);
            #1;
            waited++;
        end
        in_valid = 1'b0;
        assert (taken) else report_error("flit was not accepted before the timeout");
        model_accept(f);
    endtask

    task automatic drain(input int limit);
        int n;
        n = 0;
        while ((cpu_exp.size() != 0 || fwd_exp.size() != 0) && n < limit) begin
            idle(1);
            n++;
        end
        assert (cpu_exp.size() == 0 && fwd_exp.size() == 0)
            else report_error("expected flits did not come out before the timeout");
        idle(4);
    endtask

    // output ports are stable at the falling edge
    always @(negedge nocclk) begin : out_monitor
        flit_t    exp_c;
        tx_flit_t exp_f;
        if (rst_n && cpu_valid && cpu_ready) begin
            assert (cpu_exp.size() > 0) else report_error("unexpected flit on the cpu port");
            if (cpu_exp.size() > 0) begin
                exp_c = cpu_exp.pop_front();
                assert (cpu_flit == exp_c)
                    else mismatch("cpu_flit", 64'(exp_c), 64'(cpu_flit));
            end
        end
        if (rst_n && fwd_valid && fwd_ready) begin
            assert (fwd_exp.size() > 0) else report_error("unexpected flit on the forward port");
            if (fwd_exp.size() > 0) begin
                exp_f = fwd_exp.pop_front();
                assert (fwd_flit == exp_f)
                    else mismatch("fwd_flit", 64'(exp_f), 64'(fwd_flit));
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tests
    task automatic ignore_until_assigned();
        int n;
        test_name = "before_assign";
        assert (in_ready === 1'b1) else report_error("in_ready is low after reset");
        // dst 0 matches the node id held in reset
        send_flit(FLIT_DATA, 4'd1, 4'd0, PARENT);
        send_flit(FLIT_DATA, 4'd4, SELF, 4'd2);
        idle(6);
        assert (node_assigned === 1'b0)
            else mismatch("node_assigned", 64'd0, 64'(node_assigned));
        send_flit(FLIT_ASSIGN, 4'd0, SELF, PARENT);
        n = 0;
        while (node_assigned !== 1'b1 && n < 10) begin
            idle(1);
            n++;
        end
        assert (node_assigned === 1'b1) else report_error("node_assigned did not rise");
        assert (node_id == m_self) else mismatch("node_id", 64'(m_self), 64'(node_id));
    endtask

    task automatic route_local_and_parent();
        test_name = "local_and_parent";
        send_flit(FLIT_DATA, 4'd1, SELF, PARENT);
        // node 4 was only a source before assignment
        send_flit(FLIT_DATA, 4'd1, 4'd4, PARENT);
        send_flit(FLIT_DATA, 4'd2, 4'd12, 4'd2);
        drain(20);
    endtask

    task automatic learn_source_route();
        test_name = "learning";
        send_flit(FLIT_DATA, 4'd9, SELF, 4'd5);
        send_flit(FLIT_DATA, 4'd1, 4'd9, PARENT);
        drain(20);
    endtask

    task automatic drop_malformed();
        test_name = "malformed";
        send_flit(FLIT_DATA, 4'd1, SELF, PARENT);
        send_flit(FLIT_RSVD_2, 4'd1, SELF, PARENT);
        send_flit(FLIT_DATA, 4'd1, 4'd9, PARENT);
        send_flit(FLIT_DATA, 4'd7, 4'd7, PARENT);
        send_flit(FLIT_RSVD_3, 4'd2, 4'd11, 4'd2);
        send_flit(FLIT_DATA, 4'd2, SELF, 4'd2);
        drain(30);
    endtask

    task automatic stall_on_back_pressure();
        logic fell;
        test_name = "back_pressure";
        fell      = 1'b0;
        fwd_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    send_flit(FLIT_DATA, 4'd1, 4'd11, PARENT);
                end
            end
            begin
                for (int i = 0; i < 20 && !fell; i++) begin
                    @(negedge nocclk);
                    fell = !in_ready;
                end
                assert (fell) else report_error("in_ready never fell under back-pressure");
                idle(6);
                fwd_ready = 1'b1;
            end
        join
        drain(40);
    endtask

    task automatic expire_silent_neighbors();
        test_name = "expiry";
        send_flit(FLIT_DATA, 4'd13, SELF, 4'd4);
        send_flit(FLIT_DATA, 4'd12, 4'd13, PARENT);
        drain(20);
        // neighbor 4 goes quiet while the parent keeps talking
        repeat (REFRESHES) begin
            idle(REFRESH_GAP);
            send_flit(FLIT_DATA, 4'd12, SELF, PARENT);
            drain(20);
        end
        send_flit(FLIT_DATA, 4'd12, 4'd13, PARENT);
        drain(20);
        // parent silent too, so node 13 is unreachable
        idle(`EXPIRE_CYCLES + 40);
        send_flit(FLIT_DATA, 4'd10, 4'd13, 4'd7);
        send_flit(FLIT_DATA, 4'd10, SELF, 4'd7);
        drain(20);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    initial begin
        nocclk         = 1'b0;
        rst_n          = 1'b0;
        in_flit        = '0;
        in_valid       = 1'b0;
        cpu_ready      = 1'b1;
        fwd_ready      = 1'b1;
        seed           = 99272;
        m_assigned     = 1'b0;
        m_self         = '0;
        m_parent_valid = 1'b0;
        m_parent       = '0;
        m_tbl_valid    = '{default: 1'b0};
        m_tbl_hop      = '{default: '0};
        m_alive        = '{default: 1'b0};
        m_heard_at     = '{default: 0};
        repeat (5) @(posedge nocclk);
        #1;
        rst_n = 1'b1;
        idle(1);
        ignore_until_assigned();
        route_local_and_parent();
        learn_source_route();
        drop_malformed();
        stall_on_back_pressure();
        expire_silent_neighbors();
        if (errors == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_run();
        end
    end

    initial begin
        #(RUN_LIMIT * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", RUN_LIMIT);
        fail_run();
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+rtl
rtl/router_pkg.sv
rtl/flit_decode.sv
rtl/route_execute.sv
rtl/neighbor_monitor.sv
rtl/route_result.sv
rtl/noc_router.sv
tests/noc_router_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the router testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -f project.f --top-module noc_router_tb \
    -Mdir obj_dir > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$build_log"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/Vnoc_router_tb > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "All tests passed" "$sim_log"; then
    exit 0
fi

echo "pass message not found in $sim_log"
exit 1
